/* accel_defines.svh */
`ifndef ACCEL_DEFINES_SVH
`define ACCEL_DEFINES_SVH

// Packet memory line and DMA beat
`define ACC_DATA_WIDTH 128
`define ACC_KEEP_BYTES 16

// 256 lines in the attached memory block
`define ACC_MEM_ADDR_WIDTH 8

// Descriptor length in bytes
`define ACC_LEN_WIDTH 14

`define ACC_COUNT 2
`define ACC_PATTERN_COUNT 8

// Host register port
`define ACC_IO_ADDR_WIDTH 10
`define ACC_IO_DATA_WIDTH 32

`endif

/* accel_pkg.sv */
`include "accel_defines.svh"

package accel_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [$clog2(`ACC_COUNT)-1:0] engine_id_t;
  typedef logic [`ACC_PATTERN_COUNT-1:0] match_vec_t;

  // Count of valid bytes, 0 means a full line
  typedef struct packed {
    logic [`ACC_DATA_WIDTH-1:0]         data;
    logic [$clog2(`ACC_KEEP_BYTES)-1:0] count;
  } beat_t;

  typedef struct packed {
    engine_id_t                     engine;
    logic [`ACC_MEM_ADDR_WIDTH-1:0] addr;
    logic [`ACC_LEN_WIDTH-1:0]      len;
  } desc_t;

  // First byte on the wire sits in the top byte
  localparam logic [31:0] PATTERNS [`ACC_PATTERN_COUNT] = '{
    "GET ", "POST", "HTTP", "Host", "SYN!", "DNS?", "ssh-", "ROOT"
  };

endpackage

/* accel_rd_dma.sv */
`timescale 1ns/100ps
`include "accel_defines.svh"

module accel_rd_dma import accel_pkg::*; (
  input  logic                           clk,
  input  logic                           rst,
  input  desc_t                          desc,
  input  logic                           desc_valid,
  input  logic [`ACC_COUNT-1:0]          stop,
  output logic [`ACC_COUNT-1:0]          busy,
  output logic                           mem_en,
  output logic [`ACC_MEM_ADDR_WIDTH-1:0] mem_addr,
  input  logic [`ACC_DATA_WIDTH-1:0]     mem_rd_data,
  accel_stream_if.src                    m_stream [`ACC_COUNT]
);

  localparam int CNT_WIDTH  = $clog2(`ACC_KEEP_BYTES);
  localparam int LINE_WIDTH = `ACC_LEN_WIDTH - CNT_WIDTH + 1;

  engine_id_t                     eng_q;
  logic [LINE_WIDTH-1:0]          lines_q;
  logic [`ACC_MEM_ADDR_WIDTH-1:0] line_addr_q;
  logic [CNT_WIDTH-1:0]           tail_cnt_q;
  logic                           rd_pend_q;
  logic                           pend_last_q;
  logic                           skid_valid_q;
  logic                           skid_last_q;
  beat_t                          skid_beat_q;
  logic                           out_valid_q;
  logic                           out_last_q;
  beat_t                          out_beat_q;
  beat_t                          ret_beat;
  logic [`ACC_COUNT-1:0]          ready_vec;
  logic                           out_ready;
  logic                           out_free;
  logic                           any_busy;
  logic                           accept;
  logic                           kill;

  assign out_ready = ready_vec[eng_q];
  assign out_free  = !out_valid_q || out_ready;
  assign any_busy  = lines_q != '0 || rd_pend_q || skid_valid_q || out_valid_q;
  assign accept    = desc_valid && !any_busy;
  // Stop drops queued lines but lets the presented beat finish
  assign kill      = any_busy && stop[eng_q];
  // Only read when the returning line is sure to find room
  assign mem_en    = lines_q != '0 && !skid_valid_q && out_free && !kill;
  assign mem_addr  = line_addr_q;
  assign ret_beat  = '{data: mem_rd_data, count: pend_last_q ? tail_cnt_q : CNT_WIDTH'(0)};

  always_ff @(posedge clk) begin
    if (rst) begin
      eng_q        <= '0;
      lines_q      <= '0;
      rd_pend_q    <= 1'b0;
      skid_valid_q <= 1'b0;
      out_valid_q  <= 1'b0;
    end else begin
      rd_pend_q <= mem_en;
      if (accept) begin
        eng_q   <= desc.engine;
        lines_q <= {1'b0, desc.len[`ACC_LEN_WIDTH-1:CNT_WIDTH]} +
                   LINE_WIDTH'(|desc.len[CNT_WIDTH-1:0]);
      end else if (kill) begin
        lines_q <= '0;
      end else if (mem_en) begin
        lines_q <= lines_q - 1'b1;
      end
      if (kill) begin
        skid_valid_q <= 1'b0;
        if (out_ready)
          out_valid_q <= 1'b0;
      end else if (out_free) begin
        out_valid_q  <= skid_valid_q || rd_pend_q;
        skid_valid_q <= 1'b0;
      end else if (rd_pend_q) begin
        skid_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      line_addr_q <= desc.addr;
      tail_cnt_q  <= desc.len[CNT_WIDTH-1:0];
    end else if (mem_en) begin
      line_addr_q <= line_addr_q + 1'b1;
    end
    if (mem_en)
      pend_last_q <= lines_q == LINE_WIDTH'(1);
    if (out_free) begin
      out_beat_q <= skid_valid_q ? skid_beat_q : ret_beat;
      out_last_q <= skid_valid_q ? skid_last_q : pend_last_q;
    end else if (rd_pend_q) begin
      skid_beat_q <= ret_beat;
      skid_last_q <= pend_last_q;
    end
  end

  for (genvar g = 0; g < `ACC_COUNT; g++) begin : g_stream
    assign m_stream[g].valid   = out_valid_q && eng_q == engine_id_t'(g);
    assign m_stream[g].payload = out_beat_q;
    assign m_stream[g].last    = out_last_q;
    assign ready_vec[g]        = m_stream[g].ready;
    assign busy[g]             = any_busy && eng_q == engine_id_t'(g);
  end

endmodule

/* accel_regs.sv */
`timescale 1ns/100ps
`include "accel_defines.svh"

module accel_regs import accel_pkg::*; (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            io_en,
  input  logic                            io_wen,
  input  logic [`ACC_IO_DATA_WIDTH/8-1:0] io_strb,
  input  logic [`ACC_IO_ADDR_WIDTH-1:0]   io_addr,
  input  logic [`ACC_IO_DATA_WIDTH-1:0]   io_wr_data,
  output logic [`ACC_IO_DATA_WIDTH-1:0]   io_rd_data,
  output logic                            io_rd_valid,
  output desc_t                           desc,
  output logic                            desc_valid,
  output logic [`ACC_COUNT-1:0]           stop,
  output logic [`ACC_COUNT-1:0]           init,
  input  logic [`ACC_COUNT-1:0]           busy,
  input  match_vec_t [`ACC_COUNT-1:0]     match,
  input  logic [`ACC_COUNT-1:0]           done_pulse
);

  engine_id_t                     eng;
  logic                           sel_ok;
  logic                           wr_en;
  logic                           rd_en;
  logic                           start_wr;
  logic                           stop_wr;
  logic                           mv_rd;
  logic [`ACC_LEN_WIDTH-1:0]      len_q [`ACC_COUNT];
  logic [`ACC_MEM_ADDR_WIDTH-1:0] addr_q [`ACC_COUNT];
  match_vec_t [`ACC_COUNT-1:0]    match_q;
  logic [`ACC_COUNT-1:0]          status_done;
  logic [`ACC_COUNT-1:0]          status_match;
  logic [`ACC_COUNT-1:0]          done_d;
  logic [`ACC_COUNT-1:0]          clr;
  logic                           stall_q;
  logic [`ACC_IO_DATA_WIDTH-1:0]  rd_mux;

  // Bits 7:4 engine, bits 3:2 register
  assign eng      = engine_id_t'(io_addr[7:4]);
  assign sel_ok   = io_addr[7:4] < `ACC_COUNT;
  assign wr_en    = io_en && io_wen && !io_addr[8] && sel_ok;
  assign rd_en    = (io_en && !io_wen) || stall_q;
  assign start_wr = wr_en && io_addr[3:2] == 2'd0 && io_strb[0] && io_wr_data[0];
  assign stop_wr  = wr_en && io_addr[3:2] == 2'd0 && io_strb[0] && io_wr_data[4];
  assign mv_rd    = !io_addr[8] && sel_ok && io_addr[3:2] == 2'd3;

  always_comb begin
    for (int e = 0; e < `ACC_COUNT; e++) begin
      clr[e]          = (start_wr && eng == engine_id_t'(e)) || init[e];
      status_match[e] = |match_q[e];
    end
  end

  always_comb begin
    rd_mux = '0;
    if (io_addr[8]) begin
      rd_mux[`ACC_COUNT-1:0] = status_done | status_match;
    end else if (sel_ok) begin
      case (io_addr[3:2])
        2'd0: begin
          rd_mux[1] = busy[eng];
          rd_mux[8] = status_done[eng];
          rd_mux[9] = status_match[eng];
        end
        2'd1: rd_mux[`ACC_LEN_WIDTH-1:0] = len_q[eng];
        2'd2: rd_mux[`ACC_MEM_ADDR_WIDTH-1:0] = addr_q[eng];
        default: rd_mux[`ACC_PATTERN_COUNT-1:0] = match_q[eng];
      endcase
    end
  end

  // Command pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      desc_valid <= 1'b0;
      stop       <= '0;
      init       <= '0;
    end else begin
      desc_valid <= start_wr;
      stop       <= '0;
      init       <= '0;
      if (start_wr)
        init[eng] <= 1'b1;
      if (stop_wr)
        stop[eng] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && io_addr[3:2] == 2'd1)
      len_q[eng] <= io_wr_data[`ACC_LEN_WIDTH-1:0];
    if (wr_en && io_addr[3:2] == 2'd2)
      addr_q[eng] <= io_wr_data[`ACC_MEM_ADDR_WIDTH-1:0];
    if (start_wr)
      desc <= '{engine: eng, addr: addr_q[eng], len: len_q[eng]};
    if (rd_en)
      io_rd_data <= rd_mux;
  end

  // done_pulse is delayed one cycle so the last match pulse lands first
  always_ff @(posedge clk) begin
    if (rst) begin
      match_q     <= '0;
      status_done <= '0;
      done_d      <= '0;
    end else begin
      done_d <= done_pulse;
      for (int e = 0; e < `ACC_COUNT; e++) begin
        if (clr[e]) begin
          match_q[e]     <= '0;
          status_done[e] <= 1'b0;
        end else begin
          match_q[e] <= match_q[e] | match[e];
          if (done_d[e] || stop[e])
            status_done[e] <= 1'b1;
        end
      end
    end
  end

  // Match vector read waits for done, host holds io_addr meanwhile
  always_ff @(posedge clk) begin
    if (rst) begin
      io_rd_valid <= 1'b0;
      stall_q     <= 1'b0;
    end else if (rd_en) begin
      if (mv_rd) begin
        io_rd_valid <= status_done[eng];
        stall_q     <= !status_done[eng];
      end else begin
        io_rd_valid <= 1'b1;
        stall_q     <= 1'b0;
      end
    end else begin
      io_rd_valid <= 1'b0;
    end
  end

endmodule

/* accel_stream_if.sv */
`timescale 1ns/100ps

interface accel_stream_if #(
  parameter type payload_t = logic
) ();

  payload_t payload;
  logic     last;
  logic     valid;
  logic     ready;

  modport src (
    output payload, last, valid,
    input  ready
  );

  modport snk (
    input  payload, last, valid,
    output ready
  );

endinterface

/* accel_width_conv.sv */
`timescale 1ns/100ps
`include "accel_defines.svh"

module accel_width_conv import accel_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  accel_stream_if.snk s_stream,
  output byte_t       byte_data,
  output logic        byte_valid,
  output logic        done_pulse
);

  localparam int IDX_WIDTH = $clog2(`ACC_KEEP_BYTES);

  logic [`ACC_DATA_WIDTH-1:0] shift_q;
  logic [IDX_WIDTH-1:0]       idx_q;
  logic [IDX_WIDTH-1:0]       end_q;
  logic                       hold_q;
  logic                       last_q;
  logic                       final_byte;
  logic                       take;

  assign final_byte     = hold_q && idx_q == end_q;
  // Next beat may load as the final byte leaves
  assign s_stream.ready = !hold_q || final_byte;
  assign take           = s_stream.valid && s_stream.ready;

  assign byte_data  = shift_q[7:0];
  assign byte_valid = hold_q;
  assign done_pulse = final_byte && last_q;

  always_ff @(posedge clk) begin
    if (rst)
      hold_q <= 1'b0;
    else if (take)
      hold_q <= 1'b1;
    else if (final_byte)
      hold_q <= 1'b0;
  end

  // A count of 0 wraps to index 15, a full beat
  always_ff @(posedge clk) begin
    if (take) begin
      shift_q <= s_stream.payload.data;
      idx_q   <= '0;
      end_q   <= s_stream.payload.count - 1'b1;
      last_q  <= s_stream.last;
    end else if (hold_q) begin
      shift_q <= {8'h00, shift_q[`ACC_DATA_WIDTH-1:8]};
      idx_q   <= idx_q + 1'b1;
    end
  end

endmodule

/* accel_wrap.sv */
`timescale 1ns/100ps
`include "accel_defines.svh"

module accel_wrap import accel_pkg::*; (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            io_en,
  input  logic                            io_wen,
  input  logic [`ACC_IO_DATA_WIDTH/8-1:0] io_strb,
  input  logic [`ACC_IO_ADDR_WIDTH-1:0]   io_addr,
  input  logic [`ACC_IO_DATA_WIDTH-1:0]   io_wr_data,
  output logic [`ACC_IO_DATA_WIDTH-1:0]   io_rd_data,
  output logic                            io_rd_valid,
  output logic                            mem_en,
  output logic [`ACC_MEM_ADDR_WIDTH-1:0]  mem_addr,
  input  logic [`ACC_DATA_WIDTH-1:0]      mem_rd_data
);

  desc_t                       desc;
  logic                        desc_valid;
  logic [`ACC_COUNT-1:0]       stop;
  logic [`ACC_COUNT-1:0]       init;
  logic [`ACC_COUNT-1:0]       busy;
  logic [`ACC_COUNT-1:0]       byte_valid;
  logic [`ACC_COUNT-1:0]       done_pulse;
  match_vec_t [`ACC_COUNT-1:0] match;
  byte_t                       byte_data [`ACC_COUNT];

  accel_stream_if #(.payload_t(beat_t)) beat_if [`ACC_COUNT] ();

  accel_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .io_en      (io_en),
    .io_wen     (io_wen),
    .io_strb    (io_strb),
    .io_addr    (io_addr),
    .io_wr_data (io_wr_data),
    .io_rd_data (io_rd_data),
    .io_rd_valid(io_rd_valid),
    .desc       (desc),
    .desc_valid (desc_valid),
    .stop       (stop),
    .init       (init),
    .busy       (busy),
    .match      (match),
    .done_pulse (done_pulse)
  );

  accel_rd_dma u_rd_dma (
    .clk        (clk),
    .rst        (rst),
    .desc       (desc),
    .desc_valid (desc_valid),
    .stop       (stop),
    .busy       (busy),
    .mem_en     (mem_en),
    .mem_addr   (mem_addr),
    .mem_rd_data(mem_rd_data),
    .m_stream   (beat_if)
  );

  for (genvar g = 0; g < `ACC_COUNT; g++) begin : g_engine
    accel_width_conv u_width_conv (
      .clk       (clk),
      .rst       (rst),
      .s_stream  (beat_if[g]),
      .byte_data (byte_data[g]),
      .byte_valid(byte_valid[g]),
      .done_pulse(done_pulse[g])
    );

    // Start clears the matcher window
    pattern_sme u_sme (
      .clk       (clk),
      .rst       (rst || init[g]),
      .byte_data (byte_data[g]),
      .byte_valid(byte_valid[g]),
      .match     (match[g])
    );
  end

endmodule

/* filelist.f */
+incdir+.
accel_pkg.sv
accel_stream_if.sv
accel_regs.sv
accel_rd_dma.sv
accel_width_conv.sv
pattern_sme.sv
accel_wrap.sv
tb_accel_wrap.sv

/* pattern_sme.sv */
`timescale 1ns/100ps
`include "accel_defines.svh"

module pattern_sme import accel_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  byte_t      byte_data,
  input  logic       byte_valid,
  output match_vec_t match
);

  localparam int WIN_WIDTH = 3 * $bits(byte_t);

  logic [WIN_WIDTH-1:0]   win_q;
  logic [WIN_WIDTH+7:0]   cand;
  match_vec_t             hit;

  // Oldest byte on top, newest byte at the bottom
  assign cand = {win_q, byte_data};

  always_comb begin
    for (int p = 0; p < `ACC_PATTERN_COUNT; p++)
      hit[p] = cand == PATTERNS[p];
  end

  // Cleared window keeps bytes of the previous packet from matching
  always_ff @(posedge clk) begin
    if (rst) begin
      win_q <= '0;
      match <= '0;
    end else begin
      match <= byte_valid ? hit : '0;
      if (byte_valid)
        win_q <= cand[WIN_WIDTH-1:0];
    end
  end

endmodule

/* tb_accel_wrap.sv */
`timescale 1ns/100ps
`include "accel_defines.svh"

module tb_accel_wrap import accel_pkg::*; ();

  localparam int NUM_ROWS  = 7;
  localparam int MV_WAIT   = 3000;
  localparam int MEM_LINES = 1 << `ACC_MEM_ADDR_WIDTH;

  typedef struct packed {
    logic [3:0]       eng;
    logic [7:0]       addr;
    logic [13:0]      len;
    logic [1:0]       npat;
    logic [2:0][13:0] off;
    logic [2:0][2:0]  pat;
    logic             stop_early;
    logic [7:0]       exp_vec;
  } row_t;

  logic                            clk;
  logic                            rst;
  logic                            io_en;
  logic                            io_wen;
  logic [`ACC_IO_DATA_WIDTH/8-1:0] io_strb;
  logic [`ACC_IO_ADDR_WIDTH-1:0]   io_addr;
  logic [`ACC_IO_DATA_WIDTH-1:0]   io_wr_data;
  logic [`ACC_IO_DATA_WIDTH-1:0]   io_rd_data;
  logic                            io_rd_valid;
  logic                            mem_en;
  logic [`ACC_MEM_ADDR_WIDTH-1:0]  mem_addr;
  logic [`ACC_DATA_WIDTH-1:0]      mem_rd_data;

  logic [`ACC_DATA_WIDTH-1:0]     mem [MEM_LINES];
  logic                           rd_pend = 1'b0;
  logic [`ACC_MEM_ADDR_WIDTH-1:0] rd_addr;
  logic [`ACC_MEM_ADDR_WIDTH-1:0] exp_line;
  int                             lines_left;
  logic [31:0]                    lfsr_q;
  row_t                           rows [NUM_ROWS];
  logic                           table_ready = 1'b0;
  int                             mismatch_count;
  int                             fail_count;
  logic [7:0]                     last_vec [`ACC_COUNT];
  logic                           ran [`ACC_COUNT];

  accel_wrap u_accel_wrap (
    .clk        (clk),
    .rst        (rst),
    .io_en      (io_en),
    .io_wen     (io_wen),
    .io_strb    (io_strb),
    .io_addr    (io_addr),
    .io_wr_data (io_wr_data),
    .io_rd_data (io_rd_data),
    .io_rd_valid(io_rd_valid),
    .mem_en     (mem_en),
    .mem_addr   (mem_addr),
    .mem_rd_data(mem_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Packet memory answers one cycle after mem_en
  always @(negedge clk) begin
    if (rd_pend)
      mem_rd_data <= mem[rd_addr];
    rd_pend <= mem_en;
    rd_addr <= mem_addr;
  end

  // Reads walk the descriptor's lines in order
  always @(negedge clk) begin
    if (mem_en === 1'b1) begin
      if (lines_left <= 0) begin
        report_failure($sformatf("memory read of line 0x%h outside any descriptor", mem_addr));
      end else begin
        if (mem_addr !== exp_line)
          report_mismatch("mem_addr", 32'(mem_addr), 32'(exp_line));
        exp_line   = exp_line + 1'b1;
        lines_left = lines_left - 1;
      end
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  // Bytes stay lower case so no pattern shows up by chance
  task automatic fill_memory();
    logic [31:0] v;
    for (int line = 0; line < MEM_LINES; line++) begin
      for (int b = 0; b < `ACC_KEEP_BYTES; b++) begin
        take_bits(8, v);
        mem[line][8*b +: 8] = 8'h61 + 8'(v % 26);
      end
    end
  endtask

  function automatic logic [7:0] packet_byte(input int line, input int i);
    return mem[(line + i / 16) % MEM_LINES][8 * (i % 16) +: 8];
  endfunction

  task automatic insert_pattern(input int line, input int off, input int idx);
    logic [31:0] word;
    int          pos;
    word = PATTERNS[idx];
    for (int k = 0; k < 4; k++) begin
      pos = off + k;
      mem[(line + pos / 16) % MEM_LINES][8 * (pos % 16) +: 8] = word[31 - 8*k -: 8];
    end
  endtask

  function automatic logic [7:0] scan_packet(input int line, input int len);
    logic [31:0] w;
    logic [7:0]  v;
    v = '0;
    for (int i = 0; i + 4 <= len; i++) begin
      w = {packet_byte(line, i), packet_byte(line, i + 1),
           packet_byte(line, i + 2), packet_byte(line, i + 3)};
      for (int p = 0; p < `ACC_PATTERN_COUNT; p++) begin
        if (w == PATTERNS[p])
          v[p] = 1'b1;
      end
    end
    return v;
  endfunction

  function automatic row_t table_row(input int eng, input int addr, input int len,
                                     input int npat, input int o0, input int p0,
                                     input int o1, input int p1, input int o2,
                                     input int p2, input bit stop_early, input int exp_vec);
    row_t r;
    r.eng        = 4'(eng);
    r.addr       = 8'(addr);
    r.len        = 14'(len);
    r.npat       = 2'(npat);
    r.off        = {14'(o2), 14'(o1), 14'(o0)};
    r.pat        = {3'(p2), 3'(p1), 3'(p0)};
    r.stop_early = stop_early;
    r.exp_vec    = 8'(exp_vec);
    return r;
  endfunction

  // HTTP at 14 and POST at 15 straddle a line and POST at 34 lies past the length
  task automatic load_table();
    rows[0] = table_row(0, 0, 40, 3, 3, 0, 14, 2, 30, 3, 1'b0, 8'h0d);
    rows[1] = table_row(0, 4, 37, 3, 20, 4, 29, 5, 34, 1, 1'b0, 8'h30);
    rows[2] = table_row(0, 8, 32, 0, 0, 0, 0, 0, 0, 0, 1'b0, 8'h00);
    rows[3] = table_row(1, 12, 64, 2, 0, 6, 60, 7, 0, 0, 1'b0, 8'hc0);
    rows[4] = table_row(0, 20, 48, 1, 15, 1, 0, 0, 0, 0, 1'b0, 8'h02);
    rows[5] = table_row(1, 24, 20, 1, 16, 2, 0, 0, 0, 0, 1'b0, 8'h04);
    rows[6] = table_row(1, 40, 2000, 1, 1900, 0, 0, 0, 0, 0, 1'b1, 8'h01);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    mismatch_count++;
    $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
  endtask

  task automatic report_failure(input string msg);
    fail_count++;
    $display("ERROR: %s", msg);
  endtask

  function automatic logic [9:0] reg_addr(input int eng, input int r);
    return 10'((eng << 4) | (r << 2));
  endfunction

  task automatic reg_write(input logic [9:0] addr, input logic [31:0] data);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_strb    = 4'hf;
    io_addr    = addr;
    io_wr_data = data;
    @(negedge clk);
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  task automatic reg_read(input logic [9:0] addr, output logic [31:0] data);
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr;
    @(negedge clk);
    io_en = 1'b0;
    if (io_rd_valid !== 1'b1)
      report_failure($sformatf("no io_rd_valid one cycle after read of 0x%h", addr));
    data = io_rd_data;
    @(negedge clk);
    if (io_rd_valid !== 1'b0)
      report_failure($sformatf("io_rd_valid held past one cycle for 0x%h", addr));
  endtask

  // Address stays put while the read is stalled
  task automatic mv_read(input logic [9:0] addr, output logic [31:0] data);
    int waited;
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr;
    @(negedge clk);
    io_en  = 1'b0;
    waited = 0;
    while (io_rd_valid !== 1'b1 && waited < MV_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (io_rd_valid !== 1'b1)
      report_failure($sformatf("match vector read of 0x%h never returned", addr));
    data = io_rd_data;
    @(negedge clk);
  endtask

  task automatic wait_idle(input int eng);
    logic [31:0] rd;
    int          polls;
    rd    = 32'h2;
    polls = 0;
    while (rd[1] === 1'b1 && polls < 400) begin
      reg_read(reg_addr(eng, 0), rd);
      polls++;
    end
    if (rd[1] !== 1'b0)
      report_failure($sformatf("engine %0d stayed busy after its transfer", eng));
    // Let the converter drain its last beat
    repeat (20) @(negedge clk);
  endtask

  task automatic run_row(input int r);
    row_t        row;
    int          eng;
    logic [7:0]  scan_vec;
    logic [7:0]  want_vec;
    logic [31:0] rd;
    logic [31:0] vec;
    logic [31:0] exp_status;
    row = rows[r];
    eng = row.eng;
    for (int k = 0; k < row.npat; k++)
      insert_pattern(row.addr, row.off[k], row.pat[k]);
    scan_vec = scan_packet(row.addr, row.len);
    if (scan_vec !== row.exp_vec)
      report_mismatch("table exp_vec", row.exp_vec, scan_vec);
    // A stop lands within the first few lines, long before the inserted pattern
    want_vec = row.stop_early ? 8'h00 : scan_vec;

    reg_write(reg_addr(eng, 1), 32'(row.len));
    reg_write(reg_addr(eng, 2), 32'(row.addr));
    reg_read(reg_addr(eng, 1), rd);
    if (rd !== 32'(row.len))
      report_mismatch("len_reg", rd, 32'(row.len));
    reg_read(reg_addr(eng, 2), rd);
    if (rd !== 32'(row.addr))
      report_mismatch("addr_reg", rd, 32'(row.addr));

    exp_line   = row.addr;
    lines_left = (int'(row.len) + 15) / 16;
    reg_write(reg_addr(eng, 0), 32'h1);
    @(negedge clk);
    reg_read(reg_addr(eng, 0), rd);
    if ((rd & 32'h102) !== 32'h002)
      report_mismatch("status busy/done", rd & 32'h102, 32'h002);
    if (row.stop_early) begin
      repeat (10) @(negedge clk);
      reg_write(reg_addr(eng, 0), 32'h10);
    end

    mv_read(reg_addr(eng, 3), vec);
    if (vec !== 32'(want_vec))
      report_mismatch("match_vec", vec, 32'(want_vec));
    wait_idle(eng);
    if (!row.stop_early && lines_left != 0)
      report_failure($sformatf("DMA left %0d lines of row %0d unread", lines_left, r));
    mv_read(reg_addr(eng, 3), vec);
    if (vec !== 32'(want_vec))
      report_mismatch("match_vec after idle", vec, 32'(want_vec));

    reg_read(reg_addr(eng, 0), rd);
    exp_status = 32'h100 | ((want_vec != 0) ? 32'h200 : 32'h0);
    if ((rd & 32'h302) !== exp_status)
      report_mismatch("status final", rd & 32'h302, exp_status);
    last_vec[eng] = want_vec;
    ran[eng]      = 1'b1;

    // Other engine keeps its own vector
    for (int e = 0; e < `ACC_COUNT; e++) begin
      if (e != eng && ran[e]) begin
        mv_read(reg_addr(e, 3), vec);
        if (vec !== 32'(last_vec[e]))
          report_mismatch("other engine match_vec", vec, 32'(last_vec[e]));
      end
    end
  endtask

  initial begin
    int limit;
    wait (table_ready);
    limit = 0;
    for (int r = 0; r < NUM_ROWS; r++)
      limit += 2 * int'(rows[r].len) + 600;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not complete", limit);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    rst            = 1'b1;
    io_en          = 1'b0;
    io_wen         = 1'b0;
    io_strb        = '0;
    io_addr        = '0;
    io_wr_data     = '0;
    mem_rd_data    = '0;
    exp_line       = '0;
    lines_left     = 0;
    mismatch_count = 0;
    fail_count     = 0;
    lfsr_q         = 32'h0c7930af;
    for (int e = 0; e < `ACC_COUNT; e++) begin
      ran[e]      = 1'b0;
      last_vec[e] = '0;
    end
    load_table();
    table_ready = 1'b1;
    fill_memory();
    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    for (int r = 0; r < NUM_ROWS; r++)
      run_row(r);

    // Global status has one bit per engine
    reg_read(10'h100, rd);
    if (rd !== 32'h3)
      report_mismatch("global status", rd, 32'h3);

    $display("Errors: %0d value mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule
